/* div_pkg.sv */
`default_nettype none

package div_pkg;

    localparam int DATA_W = 32;   // APB data width and default divider width
    localparam int ADDR_W = 5;

    typedef logic [DATA_W-1:0] data_t;
    typedef logic [ADDR_W-1:0] apb_addr_t;

    // Register map, byte offsets
    localparam apb_addr_t DIVIDEND_OFS  = 5'h00;
    localparam apb_addr_t DIVISOR_OFS   = 5'h04;
    localparam apb_addr_t CTRL_OFS      = 5'h08;
    localparam apb_addr_t STATUS_OFS    = 5'h0C;
    localparam apb_addr_t QUOTIENT_OFS  = 5'h10;
    localparam apb_addr_t REMAINDER_OFS = 5'h14;

    localparam int CTRL_START_BIT  = 0;
    localparam int CTRL_SIGNED_BIT = 1;

    typedef struct packed {
        data_t dividend;
        data_t divisor;
        logic  is_signed;
    } div_req_t;

    typedef struct packed {
        data_t quotient;
        data_t remainder;
        logic  div_by_zero;
    } div_rsp_t;

    // STATUS register layout, bit 0 at the bottom
    typedef struct packed {
        logic done;         // Bit 2
        logic div_by_zero;  // Bit 1
        logic busy;         // Bit 0
    } div_status_t;

    typedef enum logic [1:0] {IDLE, RUN, FIX, DONE} ctrl_state_t;

endpackage

`default_nettype wire

/* div_core.sv */
`timescale 1ns/1ps
`default_nettype none

module div_core
    import div_pkg::*;
#(
    parameter int WIDTH = 32
)
(
    input  logic  CLK,
    input  logic  reset,
    input  logic  start,
    input  data_t dividend,
    input  data_t divisor,
    output logic  busy,
    output logic  done,
    output data_t quotient,
    output data_t remainder
);

    localparam int CNT_W = $clog2(WIDTH);

    logic [CNT_W-1:0] steps_left;   // Iterations still to run after this one
    logic [WIDTH-1:0] result;       // Dividend bits out, quotient bits in
    logic [WIDTH-1:0] denom;
    logic [WIDTH-1:0] work;         // Partial remainder
    logic [WIDTH:0]   shifted;      // Partial remainder with next dividend bit
    logic [WIDTH+1:0] trial;        // Extra top bit is the borrow
    logic             stepping;

    // Keep the full top bit of work, the divisor may use all WIDTH bits
    assign shifted  = {work, result[WIDTH-1]};
    assign trial    = {1'b0, shifted} - {2'b00, denom};
    assign stepping = busy && !done;

    always_ff @(posedge CLK)
    begin
        if (reset)
        begin
            busy       <= 1'b0;
            done       <= 1'b0;
            steps_left <= '0;
        end
        else
        begin
            done <= 1'b0;
            if (start)
            begin
                busy       <= 1'b1;
                steps_left <= CNT_W'(WIDTH - 1);
            end
            else if (done)
            begin
                busy <= 1'b0;                   // Result held until next start
            end
            else if (busy)
            begin
                if (steps_left == '0)
                begin
                    done <= 1'b1;
                end
                steps_left <= steps_left - 1'b1;
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (start)
        begin
            result <= dividend[WIDTH-1:0];
            denom  <= divisor[WIDTH-1:0];
            work   <= '0;
        end
        else if (stepping)
        begin
            if (!trial[WIDTH+1])
            begin
                work   <= trial[WIDTH-1:0];     // Difference fits, keep it
                result <= {result[WIDTH-2:0], 1'b1};
            end
            else
            begin
                work   <= shifted[WIDTH-1:0];   // Restore
                result <= {result[WIDTH-2:0], 1'b0};
            end
        end
    end

    assign quotient  = result;
    assign remainder = work;

    a_start_idle: assert property (@(posedge CLK) disable iff (reset)
        start |-> !busy);

    a_done_release: assert property (@(posedge CLK) disable iff (reset)
        done |=> !busy);

endmodule

`default_nettype wire

/* div_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module div_ctrl
    import div_pkg::*;
#(
    parameter int WIDTH = 32
)
(
    input  logic     CLK,
    input  logic     reset,
    input  logic     start,
    input  div_req_t req,
    output logic     busy,
    output logic     done,
    output div_rsp_t rsp
);

    localparam data_t MOST_NEG = {1'b1, {(WIDTH-1){1'b0}}};

    ctrl_state_t state;

    logic  dividend_neg;
    logic  divisor_neg;
    logic  zero_div;
    logic  overflow;
    logic  special;
    data_t mag_dividend;
    data_t mag_divisor;

    // Captured at start, the register block may change its operands meanwhile
    logic  neg_quot;
    logic  neg_rem;
    logic  special_q;
    logic  zero_div_q;
    data_t saved_dividend;

    logic  core_start;
    logic  core_busy;
    logic  core_done;
    data_t core_quot;
    data_t core_rem;

    assign dividend_neg = req.is_signed && req.dividend[WIDTH-1];
    assign divisor_neg  = req.is_signed && req.divisor[WIDTH-1];
    assign zero_div     = (req.divisor == '0);
    assign overflow     = req.is_signed && (req.dividend == MOST_NEG) && (req.divisor == '1);
    assign special      = zero_div || overflow;

    // Most negative value maps onto itself, which is the right unsigned magnitude
    assign mag_dividend = dividend_neg ? -req.dividend : req.dividend;
    assign mag_divisor  = divisor_neg ? -req.divisor : req.divisor;

    assign core_start = (state == IDLE) && start && !special;

    div_core #(
        .WIDTH     (WIDTH)
    ) u_core (
        .CLK       (CLK),
        .reset     (reset),
        .start     (core_start),
        .dividend  (mag_dividend),
        .divisor   (mag_divisor),
        .busy      (core_busy),
        .done      (core_done),
        .quotient  (core_quot),
        .remainder (core_rem)
    );

    always_ff @(posedge CLK)
    begin
        if (reset)
        begin
            state <= IDLE;
            done  <= 1'b0;
        end
        else
        begin
            done <= 1'b0;
            unique case (state)
                IDLE:
                begin
                    if (start)
                    begin
                        state <= special ? FIX : RUN;   // Special cases skip the core
                    end
                end
                RUN:
                begin
                    if (core_done)
                    begin
                        state <= FIX;
                    end
                end
                FIX:
                begin
                    state <= DONE;
                    done  <= 1'b1;
                end
                DONE:
                begin
                    state <= IDLE;
                end
                default:
                begin
                    state <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge CLK)
    begin
        if ((state == IDLE) && start)
        begin
            neg_quot       <= dividend_neg ^ divisor_neg;
            neg_rem        <= dividend_neg;     // Remainder follows the dividend
            special_q      <= special;
            zero_div_q     <= zero_div;
            saved_dividend <= req.dividend;
        end
        if (state == FIX)
        begin
            if (special_q)
            begin
                // Overflow returns the dividend itself, which is the most negative value
                rsp.quotient    <= zero_div_q ? '1 : saved_dividend;
                rsp.remainder   <= zero_div_q ? saved_dividend : '0;
                rsp.div_by_zero <= zero_div_q;
            end
            else
            begin
                rsp.quotient    <= neg_quot ? -core_quot : core_quot;
                rsp.remainder   <= neg_rem ? -core_rem : core_rem;
                rsp.div_by_zero <= 1'b0;
            end
        end
    end

    assign busy = (state != IDLE);

    a_done_pulse: assert property (@(posedge CLK) disable iff (reset)
        done |-> (state == DONE) ##1 !done);

    a_core_running: assert property (@(posedge CLK) disable iff (reset)
        (state == RUN) |-> core_busy);

endmodule

`default_nettype wire

/* apb_div_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module apb_div_regs
    import div_pkg::*;
(
    input  logic      CLK,
    input  logic      reset,
    input  logic      PSEL,
    input  logic      PENABLE,
    input  logic      PWRITE,
    input  apb_addr_t PADDR,
    input  data_t     PWDATA,
    output data_t     PRDATA,
    output logic      PREADY,
    output logic      PSLVERR,
    output logic      start,
    output div_req_t  req,
    input  logic      busy,
    input  logic      done,
    input  div_rsp_t  rsp,
    output logic      irq
);

    logic        access;
    logic        wr_access;
    logic        rd_access;
    logic        addr_hit;
    logic        ctrl_refused;
    logic        ctrl_accept;
    logic        status_read;
    logic        signed_mode;
    logic        zero_div_q;
    logic        done_q;
    data_t       dividend_q;
    data_t       divisor_q;
    data_t       quotient_q;
    data_t       remainder_q;
    div_status_t status;

    assign access    = PSEL && PENABLE;    // Access phase, no wait states
    assign wr_access = access && PWRITE;
    assign rd_access = access && !PWRITE;

    always_comb
    begin
        unique case (PADDR)
            DIVIDEND_OFS, DIVISOR_OFS, CTRL_OFS,
            STATUS_OFS, QUOTIENT_OFS, REMAINDER_OFS: addr_hit = 1'b1;
            default:                                 addr_hit = 1'b0;
        endcase
    end

    // A start already issued counts as busy until the controller picks it up
    assign ctrl_refused = wr_access && (PADDR == CTRL_OFS) && (busy || start);
    assign ctrl_accept  = wr_access && (PADDR == CTRL_OFS) && !(busy || start);
    assign status_read  = rd_access && (PADDR == STATUS_OFS);

    assign PREADY  = 1'b1;
    assign PSLVERR = access && (!addr_hit || ctrl_refused);

    assign status.done        = done_q;
    assign status.div_by_zero = zero_div_q;
    assign status.busy        = busy || start;

    always_comb
    begin
        PRDATA = '0;                                // Unmapped reads return zero
        unique case (PADDR)
            DIVIDEND_OFS:  PRDATA = dividend_q;
            DIVISOR_OFS:   PRDATA = divisor_q;
            CTRL_OFS:      PRDATA[CTRL_SIGNED_BIT] = signed_mode;
            STATUS_OFS:    PRDATA = data_t'(status);
            QUOTIENT_OFS:  PRDATA = quotient_q;
            REMAINDER_OFS: PRDATA = remainder_q;
            default:       PRDATA = '0;
        endcase
    end

    // Operands may be rewritten while busy, the controller has its own copy
    always_ff @(posedge CLK)
    begin
        if (wr_access && (PADDR == DIVIDEND_OFS))
        begin
            dividend_q <= PWDATA;
        end
        if (wr_access && (PADDR == DIVISOR_OFS))
        begin
            divisor_q <= PWDATA;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (reset)
        begin
            start       <= 1'b0;
            signed_mode <= 1'b0;
            zero_div_q  <= 1'b0;
            done_q      <= 1'b0;
            quotient_q  <= '0;
            remainder_q <= '0;
        end
        else
        begin
            start <= ctrl_accept && PWDATA[CTRL_START_BIT];
            if (ctrl_accept)
            begin
                signed_mode <= PWDATA[CTRL_SIGNED_BIT];
            end
            if (done)
            begin
                quotient_q  <= rsp.quotient;
                remainder_q <= rsp.remainder;
                zero_div_q  <= rsp.div_by_zero;
                done_q      <= 1'b1;                // New completion wins over a clear
            end
            else if (status_read)
            begin
                done_q <= 1'b0;
            end
        end
    end

    assign req.dividend  = dividend_q;
    assign req.divisor   = divisor_q;
    assign req.is_signed = signed_mode;

    assign irq = done_q;

    a_enable_with_select: assert property (@(posedge CLK) disable iff (reset)
        PENABLE |-> PSEL);

endmodule

`default_nettype wire

/* div_top.sv */
`timescale 1ns/1ps
`default_nettype none

module div_top
    import div_pkg::*;
#(
    parameter int WIDTH = 32
)
(
    input  logic      CLK,
    input  logic      reset,
    input  logic      PSEL,
    input  logic      PENABLE,
    input  logic      PWRITE,
    input  apb_addr_t PADDR,
    input  data_t     PWDATA,
    output data_t     PRDATA,
    output logic      PREADY,
    output logic      PSLVERR,
    output logic      irq
);

    logic     start;    // One-cycle request pulse
    logic     busy;
    logic     done;     // One-cycle completion pulse
    div_req_t req;
    div_rsp_t rsp;

    apb_div_regs u_regs (
        .CLK     (CLK),
        .reset   (reset),
        .PSEL    (PSEL),
        .PENABLE (PENABLE),
        .PWRITE  (PWRITE),
        .PADDR   (PADDR),
        .PWDATA  (PWDATA),
        .PRDATA  (PRDATA),
        .PREADY  (PREADY),
        .PSLVERR (PSLVERR),
        .start   (start),
        .req     (req),
        .busy    (busy),
        .done    (done),
        .rsp     (rsp),
        .irq     (irq)
    );

    div_ctrl #(
        .WIDTH (WIDTH)
    ) u_ctrl (
        .CLK   (CLK),
        .reset (reset),
        .start (start),
        .req   (req),
        .busy  (busy),
        .done  (done),
        .rsp   (rsp)
    );

endmodule

`default_nettype wire

/* tb_div_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_div_top
    import div_pkg::*;
();

    localparam int WIDTH           = 32;
    localparam int CLK_PERIOD      = 100;
    localparam int RESET_CYCLES    = 16;
    localparam int NUM_RANDOM      = 12;
    localparam int MAX_VEC         = 32;
    localparam int TEST_CYCLES     = 60;   // Budget per test for the watchdog
    localparam int IRQ_LIMIT       = 200;
    localparam int NORMAL_LATENCY  = WIDTH + 4;
    localparam int SPECIAL_LATENCY = 3;
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

    logic      CLK;
    logic      reset;
    logic      PSEL;
    logic      PENABLE;
    logic      PWRITE;
    apb_addr_t PADDR;
    data_t     PWDATA;
    data_t     PRDATA;
    logic      PREADY;
    logic      PSLVERR;
    logic      irq;

    data_t       vec_mem [0:5*MAX_VEC];   // Word 0 is the vector count
    logic [31:0] lfsr_state;
    int          num_vec;
    int          total_tests;
    int          tests_run;
    int          tests_failed;
    int          errors;
    int          test_errors;

    div_top #(
        .WIDTH   (WIDTH)
    ) DUT (
        .CLK     (CLK),
        .reset   (reset),
        .PSEL    (PSEL),
        .PENABLE (PENABLE),
        .PWRITE  (PWRITE),
        .PADDR   (PADDR),
        .PWDATA  (PWDATA),
        .PRDATA  (PRDATA),
        .PREADY  (PREADY),
        .PSLVERR (PSLVERR),
        .irq     (irq)
    );

    always #(CLK_PERIOD/2) CLK = ~CLK;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        lfsr_next = s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
    endfunction

    // One LFSR step per bit taken
    task automatic draw_bits(input int n, output data_t val);
        val = '0;
        for (int i = 0; i < n; i++)
        begin
            val        = {val[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    // Truncating division plus the zero divisor and overflow rules
    task automatic expected_result(input logic sgn, input data_t a, input data_t b,
                                   output data_t q, output data_t r);
        int sa;
        int sb;
        sa = a;
        sb = b;
        if (b == '0)
        begin
            q = '1;
            r = a;
        end
        else if (sgn && (a == 32'h8000_0000) && (b == '1))
        begin
            q = a;
            r = '0;
        end
        else if (sgn)
        begin
            q = sa / sb;
            r = sa % sb;
        end
        else
        begin
            q = a / b;
            r = a % b;
        end
    endtask

    task automatic report_mismatch(input string what, input data_t got, input data_t exp);
        $display("Mismatch at %0t: %s, got %h, expected %h", $time, what, got, exp);
        errors++;
        test_errors++;
    endtask

    task automatic apb_write(input apb_addr_t addr, input data_t data, input logic exp_err,
                             input string what);
        @(posedge CLK);
        PSEL    <= 1'b1;
        PENABLE <= 1'b0;
        PWRITE  <= 1'b1;
        PADDR   <= addr;
        PWDATA  <= data;
        @(posedge CLK);
        PENABLE <= 1'b1;
        @(negedge CLK);                     // Access phase, outputs settled
        if (PREADY !== 1'b1)
            report_mismatch({what, " PREADY"}, data_t'(PREADY), 32'h1);
        if (PSLVERR !== exp_err)
            report_mismatch({what, " PSLVERR"}, data_t'(PSLVERR), data_t'(exp_err));
        @(posedge CLK);
        PSEL    <= 1'b0;
        PENABLE <= 1'b0;
    endtask

    task automatic apb_read(input apb_addr_t addr, input logic exp_err, input string what,
                            output data_t data);
        @(posedge CLK);
        PSEL    <= 1'b1;
        PENABLE <= 1'b0;
        PWRITE  <= 1'b0;
        PADDR   <= addr;
        @(posedge CLK);
        PENABLE <= 1'b1;
        @(negedge CLK);
        data = PRDATA;
        if (PREADY !== 1'b1)
            report_mismatch({what, " PREADY"}, data_t'(PREADY), 32'h1);
        if (PSLVERR !== exp_err)
            report_mismatch({what, " PSLVERR"}, data_t'(PSLVERR), data_t'(exp_err));
        @(posedge CLK);
        PSEL    <= 1'b0;
        PENABLE <= 1'b0;
    endtask

    // Counts rising edges after the CTRL access edge until irq is seen
    task automatic wait_irq(output int cycles);
        cycles = 0;
        @(negedge CLK);
        while (!irq && (cycles < IRQ_LIMIT))
        begin
            @(negedge CLK);
            cycles++;
        end
        if (!irq)
        begin
            $display("Error at %0t: irq never rose after the division was started", $time);
            errors++;
            test_errors++;
        end
    endtask

    task automatic end_test(input string label);
        tests_run++;
        if (test_errors == 0)
            $display("Test %0d (%s): passed", tests_run, label);
        else
        begin
            $display("Test %0d (%s): FAILED with %0d errors", tests_run, label, test_errors);
            tests_failed++;
        end
        test_errors = 0;
    endtask

    task automatic check_results(input data_t b, input data_t exp_q, input data_t exp_r);
        data_t rd;
        apb_read(STATUS_OFS, 1'b0, "STATUS read", rd);
        if (rd[0] !== 1'b0)
            report_mismatch("STATUS busy", data_t'(rd[0]), 32'h0);
        if (rd[1] !== (b == '0))
            report_mismatch("STATUS div_by_zero", data_t'(rd[1]), data_t'(b == '0));
        if (rd[2] !== 1'b1)
            report_mismatch("STATUS done", data_t'(rd[2]), 32'h1);
        @(negedge CLK);
        if (irq !== 1'b0)
            report_mismatch("irq after STATUS read", data_t'(irq), 32'h0);
        apb_read(STATUS_OFS, 1'b0, "STATUS reread", rd);
        if (rd[2] !== 1'b0)
            report_mismatch("STATUS done after clear", data_t'(rd[2]), 32'h0);
        apb_read(QUOTIENT_OFS, 1'b0, "QUOTIENT read", rd);
        if (rd !== exp_q)
            report_mismatch("QUOTIENT", rd, exp_q);
        apb_read(REMAINDER_OFS, 1'b0, "REMAINDER read", rd);
        if (rd !== exp_r)
            report_mismatch("REMAINDER", rd, exp_r);
    endtask

    task automatic run_division(input logic sgn, input data_t a, input data_t b,
                                input data_t exp_q, input data_t exp_r, input string label);
        int cycles;
        int exp_cycles;
        apb_write(DIVIDEND_OFS, a, 1'b0, "DIVIDEND write");
        apb_write(DIVISOR_OFS, b, 1'b0, "DIVISOR write");
        apb_write(CTRL_OFS, sgn ? 32'h3 : 32'h1, 1'b0, "CTRL write");
        wait_irq(cycles);
        exp_cycles = ((b == '0) || (sgn && (a == 32'h8000_0000) && (b == '1)))
                     ? SPECIAL_LATENCY : NORMAL_LATENCY;
        if (irq && (cycles != exp_cycles))
            report_mismatch("irq latency in cycles", data_t'(cycles), data_t'(exp_cycles));
        check_results(b, exp_q, exp_r);
        end_test(label);
    endtask

    // A second start while busy is refused and the first result survives
    task automatic busy_write_test();
        int    cycles;
        data_t exp_q;
        data_t exp_r;
        expected_result(1'b0, 32'd1000, 32'd7, exp_q, exp_r);
        apb_write(DIVIDEND_OFS, 32'd1000, 1'b0, "DIVIDEND write");
        apb_write(DIVISOR_OFS, 32'd7, 1'b0, "DIVISOR write");
        apb_write(CTRL_OFS, 32'h1, 1'b0, "CTRL write");
        apb_write(CTRL_OFS, 32'h3, 1'b1, "CTRL write while busy");
        apb_write(DIVIDEND_OFS, 32'd5, 1'b0, "DIVIDEND write while busy");
        wait_irq(cycles);
        check_results(32'd7, exp_q, exp_r);
        end_test("CTRL write while busy");
    endtask

    task automatic unmapped_test();
        data_t rd;
        apb_read(5'h18, 1'b1, "Unmapped read", rd);
        if (rd !== '0)
            report_mismatch("Unmapped read data", rd, 32'h0);
        apb_write(5'h1C, 32'hA5A5_A5A5, 1'b1, "Unmapped write");
        end_test("unmapped address");
    endtask

    initial
    begin
        data_t sgn;
        data_t a;
        data_t b;
        data_t sh;
        data_t exp_q;
        data_t exp_r;
        CLK          = 1'b0;
        reset        = 1'b1;
        PSEL         = 1'b0;
        PENABLE      = 1'b0;
        PWRITE       = 1'b0;
        PADDR        = '0;
        PWDATA       = '0;
        errors       = 0;
        test_errors  = 0;
        tests_run    = 0;
        tests_failed = 0;
        lfsr_state   = 32'h1ce7;
        $readmemh("div_input.txt", vec_mem);
        num_vec = int'(vec_mem[0]);
        if (num_vec > MAX_VEC)
            num_vec = MAX_VEC;
        total_tests = num_vec + NUM_RANDOM + 2;
        repeat (RESET_CYCLES) @(posedge CLK);
        reset <= 1'b0;
        for (int i = 0; i < num_vec; i++)
        begin
            run_division(vec_mem[5*i+1][0], vec_mem[5*i+2], vec_mem[5*i+3],
                         vec_mem[5*i+4], vec_mem[5*i+5], "file vector");
        end
        for (int i = 0; i < NUM_RANDOM; i++)
        begin
            draw_bits(1, sgn);
            draw_bits(32, a);
            draw_bits(5, sh);
            draw_bits(32, b);
            b = b >> sh[4:0];               // Spread divisor sizes
            expected_result(sgn[0], a, b, exp_q, exp_r);
            run_division(sgn[0], a, b, exp_q, exp_r, "random");
        end
        busy_write_test();
        unmapped_test();
        $display("Summary: %0d run, %0d passed, %0d with errors, %0d errors in total",
                 tests_run, tests_run - tests_failed, tests_failed, errors);
        if (errors == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

    initial
    begin
        wait (total_tests != 0);
        #((total_tests * TEST_CYCLES + RESET_CYCLES) * CLK_PERIOD);
        $display("Timeout: the run took longer than %0d cycles",
                 total_tests * TEST_CYCLES + RESET_CYCLES);
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

/* div_input.txt */
// First word: number of vectors, in hex
// Then per line: mode (0 unsigned, 1 signed) dividend divisor quotient remainder
00000011
0 00000064 00000007 0000000e 00000002
0 ffffffff 00000001 ffffffff 00000000
0 ffffffff ffffffff 00000001 00000000
0 00000005 0000000a 00000000 00000005
0 80000000 00000003 2aaaaaaa 00000002
0 12345678 00000000 ffffffff 12345678
0 fffffffe 80000000 00000001 7ffffffe
1 00000064 00000007 0000000e 00000002
1 ffffff9c 00000007 fffffff2 fffffffe
1 00000064 fffffff9 fffffff2 00000002
1 ffffff9c fffffff9 0000000e fffffffe
1 80000000 ffffffff 80000000 00000000
1 80000000 00000000 ffffffff 80000000
1 80000000 00000001 80000000 00000000
1 80000000 00000002 c0000000 00000000
1 7fffffff 80000000 00000000 7fffffff
1 fffffffb 00000003 ffffffff fffffffe

/* project.f */
div_pkg.sv
div_core.sv
div_ctrl.sv
apb_div_regs.sv
div_top.sv
tb_div_top.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_div_top -f project.f -o sim_div
if [ $? -ne 0 ]; then
    echo "Verilator compile step returned an error"
    exit 1
fi

./obj_dir/sim_div > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Test failed" sim.log; then
    exit 1
fi
exit 0
